// File: adder/approx_adder.sv
`timescale 1ns/10ps
`include "apx_alu_macros.svh"

module approx_adder #(
    parameter int LEN     = `XLEN,
    parameter int APX_LEN = `APX_LEN     // Multiple of 4
) (
    input  logic [APX_LEN-1:0] er,
    input  logic [LEN-1:0]     a,
    input  logic [LEN-1:0]     b,
    input  logic               cin,
    output logic [LEN-1:0]     sum
);

    localparam int NUM_BLK = (LEN - APX_LEN) / 4;   // Exact 4-bit blocks

    logic [APX_LEN:0] apx_c;                         // Ripple carries, low part
    logic [NUM_BLK:0] blk_c;                         // Carry into each block

    assign apx_c[0] = cin;

    // --------------------
    // Error-configurable full adders
    // er = 1 gives an exact bit
    for (genvar i = 0; i < APX_LEN; i++) begin : g_ecfa
        logic x;                                     // Half sum
        assign x          = a[i] ^ b[i];
        assign sum[i]     = ~(er[i] & x & apx_c[i]) & (x | apx_c[i]);
        assign apx_c[i+1] = (er[i] & b[i] & apx_c[i]) | ((b[i] | apx_c[i]) & a[i]);
    end

    assign blk_c[0] = apx_c[APX_LEN];

    // --------------------
    // Exact carry-select upper part
    for (genvar k = 0; k < NUM_BLK; k++) begin : g_csel
        localparam int LSB = APX_LEN + 4 * k;
        logic [4:0] s0;                              // Carry-in 0 guess
        logic [4:0] s1;                              // Carry-in 1 guess

        assign s0 = {1'b0, a[LSB+3:LSB]} + {1'b0, b[LSB+3:LSB]};
        assign s1 = {1'b0, a[LSB+3:LSB]} + {1'b0, b[LSB+3:LSB]} + 5'd1;

        // Late carry picks one of the two
        assign {blk_c[k+1], sum[LSB+3:LSB]} = blk_c[k] ? s1 : s0;
    end

endmodule

// File: apx_alu.f
+incdir+common
common/apx_alu_pkg.sv
adder/approx_adder.sv
hw/alu_decode.sv
hw/alu_op_fifo.sv
hw/alu_execute.sv
hw/apx_alu_top.sv
verif/alu_tb_clkgen.sv
verif/apx_alu_sva.sv
verif/apx_alu_tb.sv

// File: common/apx_alu_macros.svh
`ifndef APX_ALU_MACROS_SVH
`define APX_ALU_MACROS_SVH

// --------------------
// Widths
`define XLEN          32          // Data path width
`define APX_LEN       8           // Approximate low bits, multiple of 4

// --------------------
// RV32I major opcodes
`define OPC_OP        7'b0110011  // R-type ALU
`define OPC_OP_IMM    7'b0010011  // I-type ALU

// funct3 groups
`define F3_ADD        3'b000
`define F3_SLL        3'b001
`define F3_SLT        3'b010
`define F3_SLTU       3'b011
`define F3_XOR        3'b100
`define F3_SR         3'b101      // SRL / SRA share funct3
`define F3_OR         3'b110
`define F3_AND        3'b111

`define F7_BASE       7'b0000000
`define F7_ALT        7'b0100000  // SUB, SRA, SRAI

`define OP_FIFO_DEPTH 2           // Entries between decode and execute

`endif

// File: common/apx_alu_pkg.sv
`include "apx_alu_macros.svh"

package apx_alu_pkg;

    // --------------------
    // Instruction word, two decodes of the same 32 bits
    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } instr_r_t;

    typedef struct packed {
        logic [11:0] imm;                // Sign extended later
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } instr_i_t;

    typedef union packed {
        instr_r_t r_fields;              // OP view
        instr_i_t i_fields;              // OP-IMM view
    } instr_u;

    // Decoded ALU function
    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_SLL,
        ALU_SLT,
        ALU_SLTU,
        ALU_XOR,
        ALU_SRL,
        ALU_SRA,
        ALU_OR,
        ALU_AND,
        ALU_ILLEGAL
    } alu_fn_e;

    // --------------------
    // Accuracy control CSR, bit 0 at the bottom
    typedef struct packed {
        logic [28:0] error_control;      // Bits 31:3, low APX_LEN used
        logic [1:0]  circuit_select;     // Single adder, ignored
        logic        approximate;        // 1 = approximate adds
    } accuracy_csr_t;

    // --------------------
    // Pipeline payloads
    typedef struct packed {
        instr_u                   instr;
        logic [`XLEN-1:0]         rs1_val;
        logic [`XLEN-1:0]         rs2_val;
        accuracy_csr_t            csr;
    } alu_req_t;

    typedef struct packed {
        alu_fn_e                  fn;
        logic [`XLEN-1:0]         operand_1;
        logic [`XLEN-1:0]         operand_2;
        logic [`APX_LEN-1:0]      er;    // Per-bit error enable, 1 = exact
    } alu_op_t;

    typedef struct packed {
        logic [`XLEN-1:0]         result;
        logic                     illegal;
    } alu_rsp_t;

endpackage

// File: hw/alu_decode.sv
`timescale 1ns/10ps
`include "apx_alu_macros.svh"

module alu_decode import apx_alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     in_valid,
    output logic     in_ready,
    input  alu_req_t in_req,
    output logic     dec_valid,
    input  logic     dec_ready,
    output alu_op_t  dec_op
);

    localparam int SHW = $clog2(`XLEN);  // Shift amount width

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    logic [6:0]       funct7;
    logic [`XLEN-1:0] imm_sext;
    logic             use_imm;
    logic             is_shift;
    logic [`XLEN-1:0] op2_raw;
    alu_fn_e          fn;
    alu_op_t          next_op;

    // Base operation for a funct3 code, funct7 checked by caller
    function automatic alu_fn_e f3_fn(input logic [2:0] f3);
        case (f3)
            `F3_ADD:  return ALU_ADD;
            `F3_SLL:  return ALU_SLL;
            `F3_SLT:  return ALU_SLT;
            `F3_SLTU: return ALU_SLTU;
            `F3_XOR:  return ALU_XOR;
            `F3_SR:   return ALU_SRL;
            `F3_OR:   return ALU_OR;
            default:  return ALU_AND;
        endcase
    endfunction

    // --------------------
    // Field extraction
    assign opcode   = in_req.instr.r_fields.opcode;
    assign funct3   = in_req.instr.r_fields.funct3;
    assign funct7   = in_req.instr.r_fields.funct7;   // Upper imm bits on OP-IMM
    assign imm_sext = {{(`XLEN-12){in_req.instr.i_fields.imm[11]}}, in_req.instr.i_fields.imm};

    always_comb begin
        fn      = ALU_ILLEGAL;
        use_imm = 1'b0;
        case (opcode)
            `OPC_OP: begin
                if (funct7 == `F7_BASE)
                    fn = f3_fn(funct3);
                else if (funct7 == `F7_ALT && funct3 == `F3_ADD)
                    fn = ALU_SUB;
                else if (funct7 == `F7_ALT && funct3 == `F3_SR)
                    fn = ALU_SRA;
            end
            `OPC_OP_IMM: begin
                use_imm = 1'b1;
                if (funct3 == `F3_SLL) begin
                    if (funct7 == `F7_BASE)
                        fn = ALU_SLL;                     // SLLI
                end else if (funct3 == `F3_SR) begin
                    if (funct7 == `F7_BASE)
                        fn = ALU_SRL;
                    else if (funct7 == `F7_ALT)
                        fn = ALU_SRA;                     // SRAI
                end else begin
                    fn = f3_fn(funct3);                   // No funct7 on these
                end
            end
            default: fn = ALU_ILLEGAL;                    // Unsupported opcode
        endcase
    end

    assign is_shift = (fn == ALU_SLL) || (fn == ALU_SRL) || (fn == ALU_SRA);
    assign op2_raw  = use_imm ? imm_sext : in_req.rs2_val;

    always_comb begin
        next_op.fn        = fn;
        next_op.operand_1 = in_req.rs1_val;
        next_op.operand_2 = is_shift ? {{(`XLEN-SHW){1'b0}}, op2_raw[SHW-1:0]} : op2_raw;
        // Exact bits forced on when approximation is off
        next_op.er = in_req.csr.error_control[`APX_LEN-1:0]
                   | {`APX_LEN{~in_req.csr.approximate}};
    end

    // --------------------
    // One-entry output stage
    assign in_ready = !dec_valid || dec_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            dec_valid <= 1'b0;
        end else if (in_valid && in_ready) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;                            // Taken, nothing new
        end
    end

    always_ff @(posedge clk) begin
        if (in_valid && in_ready)
            dec_op <= next_op;
    end

endmodule

// File: hw/alu_execute.sv
`timescale 1ns/10ps
`include "apx_alu_macros.svh"

module alu_execute import apx_alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     op_valid,
    output logic     op_ready,
    input  alu_op_t  op,
    output logic     out_valid,
    input  logic     out_ready,
    output alu_rsp_t out_rsp
);

    localparam int SHW = $clog2(`XLEN);

    logic [`XLEN-1:0] add_b;
    logic             add_cin;
    logic [`XLEN-1:0] add_sum;
    logic [SHW-1:0]   shamt;
    alu_rsp_t         next_rsp;

    // --------------------
    // Adder path, SUB as a + ~b + 1
    assign add_cin = (op.fn == ALU_SUB);
    assign add_b   = add_cin ? ~op.operand_2 : op.operand_2;

    approx_adder #(
        .LEN     (`XLEN),
        .APX_LEN (`APX_LEN)
    ) u_adder (
        .er  (op.er),
        .a   (op.operand_1),
        .b   (add_b),
        .cin (add_cin),
        .sum (add_sum)
    );

    assign shamt = op.operand_2[SHW-1:0];      // Already masked by decode

    always_comb begin
        next_rsp.illegal = 1'b0;
        case (op.fn)
            ALU_ADD,
            ALU_SUB:  next_rsp.result = add_sum;
            ALU_SLL:  next_rsp.result = op.operand_1 << shamt;
            ALU_SLT:  next_rsp.result = {{(`XLEN-1){1'b0}},
                                         $signed(op.operand_1) < $signed(op.operand_2)};
            ALU_SLTU: next_rsp.result = {{(`XLEN-1){1'b0}}, op.operand_1 < op.operand_2};
            ALU_XOR:  next_rsp.result = op.operand_1 ^ op.operand_2;
            ALU_SRL:  next_rsp.result = op.operand_1 >> shamt;
            ALU_SRA:  next_rsp.result = $unsigned($signed(op.operand_1) >>> shamt); // Sign fill
            ALU_OR:   next_rsp.result = op.operand_1 | op.operand_2;
            ALU_AND:  next_rsp.result = op.operand_1 & op.operand_2;
            default: begin
                next_rsp.result  = '0;         // Illegal encoding
                next_rsp.illegal = 1'b1;
            end
        endcase
    end

    // --------------------
    // Output register, held until taken
    assign op_ready = !out_valid || out_ready;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            out_valid <= 1'b0;
        end else if (op_valid && op_ready) begin
            out_valid <= 1'b1;
        end else if (out_ready) begin
            out_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (op_valid && op_ready)
            out_rsp <= next_rsp;
    end

endmodule

// File: hw/alu_op_fifo.sv
`timescale 1ns/10ps
`include "apx_alu_macros.svh"

module alu_op_fifo import apx_alu_pkg::*; #(
    parameter int DEPTH = `OP_FIFO_DEPTH
) (
    input  logic    clk,
    input  logic    rst_n,
    input  logic    wr_valid,
    output logic    wr_ready,
    input  alu_op_t wr_op,
    output logic    rd_valid,
    input  logic    rd_ready,
    output alu_op_t rd_op
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    alu_op_t          mem [DEPTH];    // Storage, no reset
    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             do_wr;
    logic             do_rd;

    // --------------------
    // Flags
    assign wr_ready = (count < CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_op    = mem[rd_ptr];             // Head entry

    assign do_wr = wr_valid && wr_ready;
    assign do_rd = rd_valid && rd_ready;

    // Pointer wrap helper
    function automatic logic [PTR_W-1:0] ptr_inc(input logic [PTR_W-1:0] p);
        if (p == PTR_W'(DEPTH - 1))
            return '0;
        return p + 1'b1;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_wr)
                wr_ptr <= ptr_inc(wr_ptr);
            if (do_rd)
                rd_ptr <= ptr_inc(rd_ptr);
            // Simultaneous push and pop keeps count
            if (do_wr && !do_rd)
                count <= count + 1'b1;
            else if (do_rd && !do_wr)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_wr)
            mem[wr_ptr] <= wr_op;
    end

endmodule

// File: hw/apx_alu_top.sv
`timescale 1ns/10ps

module apx_alu_top import apx_alu_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    // Request channel
    input  logic     in_valid,
    output logic     in_ready,
    input  alu_req_t in_req,
    // Response channel
    output logic     out_valid,
    input  logic     out_ready,
    output alu_rsp_t out_rsp
);

    // --------------------
    // Internal links
    logic    dec_valid;
    logic    dec_ready;
    alu_op_t dec_op;
    logic    fifo_valid;
    logic    fifo_ready;
    alu_op_t fifo_op;

    alu_decode u_decode (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .dec_valid (dec_valid),
        .dec_ready (dec_ready),
        .dec_op    (dec_op)
    );

    alu_op_fifo u_fifo (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_valid (dec_valid),
        .wr_ready (dec_ready),
        .wr_op    (dec_op),
        .rd_valid (fifo_valid),
        .rd_ready (fifo_ready),
        .rd_op    (fifo_op)
    );

    alu_execute u_execute (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (fifo_valid),
        .op_ready  (fifo_ready),
        .op        (fifo_op),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

endmodule

// File: verif/alu_tb_clkgen.sv
`timescale 1ns/10ps

module alu_tb_clkgen #(
    parameter real PERIOD = 4.0         // ns
) (
    output logic clk
);

    // Free running, starts low
    initial begin
        clk = 1'b0;
        forever #(PERIOD / 2.0) clk = ~clk;
    end

endmodule

// File: verif/apx_alu_sva.sv
`timescale 1ns/10ps

module apx_alu_sva import apx_alu_pkg::*; (
    input logic     clk,
    input logic     rst_n,
    input logic     in_valid,
    input logic     in_ready,
    input alu_req_t in_req,
    input logic     out_valid,
    input logic     out_ready,
    input alu_rsp_t out_rsp
);

    logic [2:0] in_flight;              // Accepted, not yet delivered

    always_ff @(posedge clk) begin
        if (!rst_n)
            in_flight <= '0;
        else
            in_flight <= in_flight + (in_valid && in_ready) - (out_valid && out_ready);
    end

    // --------------------
    // Stalled payloads hold
    a_in_hold: assert property (@(posedge clk) disable iff (!rst_n)
        in_valid && !in_ready |=> in_valid && $stable(in_req))
        else $error("Request payload changed while stalled");

    a_out_hold: assert property (@(posedge clk) disable iff (!rst_n)
        out_valid && !out_ready |=> out_valid && $stable(out_rsp))
        else $error("Response payload changed while stalled");

    // Quiet output in reset
    a_rst_quiet: assert property (@(posedge clk) !rst_n |=> !out_valid)
        else $error("out_valid high during reset");

    // Four slots: decoder, two FIFO entries, executor
    a_room: assert property (@(posedge clk) disable iff (!rst_n)
        (in_flight < 3'd4) |-> in_ready)
        else $error("in_ready low with a free pipeline slot");

endmodule

bind apx_alu_top apx_alu_sva u_sva (.*);

// File: verif/apx_alu_tb.sv
`timescale 1ns/10ps
`include "apx_alu_macros.svh"

module apx_alu_tb import apx_alu_pkg::*; ();

    typedef struct {
        alu_req_t         req;
        logic [`XLEN-1:0] exp_result;
        logic             exp_illegal;
    } vec_t;

    logic     clk;
    logic     rst_n;
    logic     in_valid;
    logic     in_ready;
    alu_req_t in_req;
    logic     out_valid;
    logic     out_ready;
    alu_rsp_t out_rsp;

    vec_t   tbl[$];                     // Stimulus and expected values
    int     exp_q[$];                   // Table indices in request order
    int     rcv_count;
    int     cycles;
    int     limit;
    integer seed;

    alu_tb_clkgen u_clkgen (.clk(clk));

    apx_alu_top dut (
        .clk       (clk),
        .rst_n     (rst_n),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .in_req    (in_req),
        .out_valid (out_valid),
        .out_ready (out_ready),
        .out_rsp   (out_rsp)
    );

    // --------------------
    // Encoders with fixed register numbers
    function automatic logic [31:0] encode_r(input logic [6:0] f7, input logic [2:0] f3);
        return {f7, 5'd3, 5'd2, f3, 5'd1, `OPC_OP};
    endfunction

    function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [2:0] f3);
        return {imm, 5'd2, f3, 5'd1, `OPC_OP_IMM};
    endfunction

    function automatic logic [31:0] approx_csr(input logic [7:0] er);
        return {21'd0, er, 2'b00, 1'b1};            // Approximate bit set
    endfunction

    // Error-configurable low bits over an exact upper sum
    function automatic logic [31:0] model_add(input logic [31:0] a, input logic [31:0] b,
                                              input logic cin, input logic [7:0] er);
        logic        c;
        logic [31:0] s;
        logic [24:0] hi;
        c = cin;
        for (int i = 0; i < 8; i++) begin
            if (er[i] && (a[i] ^ b[i]) && c)
                s[i] = 1'b0;
            else
                s[i] = (a[i] ^ b[i]) | c;
            c = (er[i] & b[i] & c) | ((b[i] | c) & a[i]);
        end
        hi       = {1'b0, a[31:8]} + {1'b0, b[31:8]} + c;
        s[31:8]  = hi[23:0];
        return s;
    endfunction

    // Reference ALU following RV32I rules
    function automatic alu_rsp_t model_alu(input logic [31:0] instr, input logic [31:0] rs1,
                                           input logic [31:0] rs2, input logic [31:0] csr);
        logic [6:0]  opc;
        logic [2:0]  f3;
        logic [6:0]  f7;
        logic [31:0] b;
        logic [7:0]  er;
        logic [4:0]  sh;
        logic        legal;
        alu_rsp_t    rsp;
        opc = instr[6:0];
        f3  = instr[14:12];
        f7  = instr[31:25];
        er  = csr[0] ? csr[10:3] : 8'hff;           // Exact when not approximate
        b   = (opc == `OPC_OP) ? rs2 : {{20{instr[31]}}, instr[31:20]};
        sh  = b[4:0];
        if (opc == `OPC_OP)
            legal = (f7 == 7'h00) || (f7 == 7'h20 && (f3 == 3'd0 || f3 == 3'd5));
        else if (opc == `OPC_OP_IMM)
            legal = (f3 == 3'd1) ? (f7 == 7'h00) :
                    (f3 == 3'd5) ? (f7 == 7'h00 || f7 == 7'h20) : 1'b1;
        else
            legal = 1'b0;
        rsp.illegal = !legal;
        rsp.result  = '0;
        if (legal) begin
            case (f3)
                3'd0: rsp.result = (opc == `OPC_OP && f7[5]) ? model_add(rs1, ~b, 1'b1, er)
                                                             : model_add(rs1, b, 1'b0, er);
                3'd1: rsp.result = rs1 << sh;
                3'd2: rsp.result = ($signed(rs1) < $signed(b)) ? 32'd1 : 32'd0;
                3'd3: rsp.result = (rs1 < b) ? 32'd1 : 32'd0;
                3'd4: rsp.result = rs1 ^ b;
                3'd5: begin
                    rsp.result = rs1 >> sh;
                    if (f7[5] && rs1[31])
                        rsp.result = rsp.result | ~(32'hffff_ffff >> sh);  // Sign fill
                end
                3'd6: rsp.result = rs1 | b;
                default: rsp.result = rs1 & b;
            endcase
        end
        return rsp;
    endfunction

    task automatic add_vector(input logic [31:0] instr, input logic [31:0] rs1,
                              input logic [31:0] rs2, input logic [31:0] csr);
        vec_t     v;
        alu_rsp_t rsp;
        rsp           = model_alu(instr, rs1, rs2, csr);
        v.req.instr   = instr;
        v.req.rs1_val = rs1;
        v.req.rs2_val = rs2;
        v.req.csr     = csr;
        v.exp_result  = rsp.result;
        v.exp_illegal = rsp.illegal;
        tbl.push_back(v);
    endtask

    // --------------------
    task automatic build_table();
        logic [31:0] r;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] c;
        add_vector(encode_r(7'h00, 3'd0), 32'd5, 32'd7, 32'h0);
        add_vector(encode_r(7'h00, 3'd0), 32'hffff_ffff, 32'd2, 32'h0);   // Wraps
        add_vector(encode_r(7'h20, 3'd0), 32'd3, 32'd5, 32'h0);
        add_vector(encode_r(7'h20, 3'd0), 32'h8000_0000, 32'd1, 32'h6);   // Select bits set
        add_vector(encode_i(12'hfff, 3'd0), 32'd0, 32'h0, 32'h0);         // ADDI -1
        add_vector(encode_i(12'h800, 3'd0), 32'd100, 32'h0, 32'h0);
        // Approximate adds
        add_vector(encode_r(7'h00, 3'd0), 32'h0000_00ff, 32'd1, approx_csr(8'h00));
        add_vector(encode_r(7'h00, 3'd0), 32'h1234_5678, 32'h0f0f_0f0f, approx_csr(8'ha5));
        add_vector(encode_r(7'h20, 3'd0), 32'd100, 32'd37, approx_csr(8'h0f));
        add_vector(encode_i(12'h7ff, 3'd0), 32'h0000_0001, 32'h0, approx_csr(8'h00));
        add_vector(encode_r(7'h00, 3'd0), 32'hdead_beef, 32'h1111_1111, approx_csr(8'hff));
        // Logic and compare
        add_vector(encode_r(7'h00, 3'd4), 32'hf0f0_1234, 32'h0ff0_4321, 32'h0);
        add_vector(encode_r(7'h00, 3'd6), 32'hf000_0001, 32'h0000_f010, 32'h0);
        add_vector(encode_r(7'h00, 3'd7), 32'hff00_ff00, 32'h0ff0_0ff0, 32'h0);
        add_vector(encode_i(12'h8f0, 3'd4), 32'h1234_5678, 32'h0, 32'h0);
        add_vector(encode_i(12'h00f, 3'd6), 32'h1234_5670, 32'h0, 32'h0);
        add_vector(encode_i(12'hff0, 3'd7), 32'h1234_5678, 32'h0, 32'h0);
        add_vector(encode_r(7'h00, 3'd2), 32'hffff_ffff, 32'd1, 32'h0);       // Signed
        add_vector(encode_r(7'h00, 3'd3), 32'hffff_ffff, 32'd1, 32'h0);       // Unsigned
        add_vector(encode_i(12'hffe, 3'd2), 32'hffff_fffb, 32'h0, 32'h0);
        add_vector(encode_i(12'hfff, 3'd3), 32'd5, 32'h0, 32'h0);
        // Shifts use the low 5 amount bits
        add_vector(encode_r(7'h00, 3'd1), 32'd1, 32'h0000_0023, 32'h0);
        add_vector(encode_r(7'h00, 3'd5), 32'h8000_0000, 32'h0000_003f, 32'h0);
        add_vector(encode_r(7'h20, 3'd5), 32'h8000_0000, 32'd4, 32'h0);
        add_vector(encode_i(12'h005, 3'd1), 32'h0000_0003, 32'h0, 32'h0);
        add_vector(encode_i(12'h008, 3'd5), 32'hf000_0000, 32'h0, 32'h0);
        add_vector(encode_i(12'h408, 3'd5), 32'hf000_0000, 32'h0, 32'h0);     // SRAI
        // Illegal encodings
        add_vector(encode_r(7'h01, 3'd0), 32'd1, 32'd2, 32'h0);
        add_vector(encode_r(7'h20, 3'd4), 32'd1, 32'd2, 32'h0);
        add_vector(encode_i(12'h401, 3'd1), 32'd1, 32'h0, 32'h0);            // SLLI with f7 bit 5
        add_vector(encode_i(12'h202, 3'd5), 32'd1, 32'h0, 32'h0);
        add_vector(32'h0000_10b7, 32'd1, 32'd2, 32'h0);                       // LUI
        add_vector(32'h0000_0097, 32'd1, 32'd2, 32'h0);                       // AUIPC
        // Random mix of both opcodes
        for (int k = 0; k < 24; k++) begin
            r = $random(seed);
            a = $random(seed);
            b = $random(seed);
            c = $random(seed);
            add_vector({r[31] ? 7'h20 : 7'h00, r[30:26], 5'd2, r[14:12], 5'd1,
                        r[0] ? `OPC_OP : `OPC_OP_IMM}, a, b, c);
        end
    endtask

    // --------------------
    task automatic stop_with_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1, "Run stopped at first error");
    endtask

    task automatic check_result(input logic [`XLEN-1:0] got, input logic [`XLEN-1:0] exp,
                                input int idx);
        if (got !== exp)
            stop_with_failure($sformatf(
                "ERROR at %0t: out_rsp.result = %h, expected %h (vector %0d)",
                $time, got, exp, idx));
    endtask

    task automatic check_illegal(input logic got, input logic exp, input int idx);
        if (got !== exp)
            stop_with_failure($sformatf(
                "ERROR at %0t: out_rsp.illegal = %b, expected %b (vector %0d)",
                $time, got, exp, idx));
    endtask

    // --------------------
    // Response side and random back-pressure
    always @(posedge clk) begin
        int idx;
        if (rst_n && out_valid && out_ready) begin
            if (exp_q.size() == 0) begin
                stop_with_failure("Response arrived with no request outstanding");
            end else begin
                idx = exp_q.pop_front();
                check_result(out_rsp.result, tbl[idx].exp_result, idx);
                check_illegal(out_rsp.illegal, tbl[idx].exp_illegal, idx);
                rcv_count++;
            end
        end
        out_ready <= ($random(seed) & 1) != 0;
    end

    always @(posedge clk) begin
        cycles++;
        if (cycles > limit)
            stop_with_failure($sformatf("Timeout after %0d cycles, %0d of %0d responses seen",
                                        cycles, rcv_count, tbl.size()));
    end

    initial begin
        rst_n     = 1'b0;
        in_valid  = 1'b0;
        in_req    = '0;
        out_ready = 1'b0;
        seed      = 32'hf595;
        rcv_count = 0;
        cycles    = 0;
        build_table();
        limit = tbl.size() * 20 + 100;
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        foreach (tbl[i]) begin
            in_valid <= 1'b1;
            in_req   <= tbl[i].req;
            exp_q.push_back(i);
            @(posedge clk);
            while (!in_ready)                       // Hold until accepted
                @(posedge clk);
        end
        in_valid <= 1'b0;
        while (rcv_count < tbl.size())
            @(posedge clk);
        repeat (10) @(posedge clk);                 // Room for stray responses
        if (!out_valid) begin
            $display("SIMULATION PASSED");
            $finish;
        end else begin
            stop_with_failure("Extra response still pending after all expected responses");
        end
    end

endmodule
